/* evo_xb.f */
source/evo_csr_pkg.sv
source/evo_pmux_pkg.sv
source/evo_xb_info.sv
source/evo_pmux_csr.sv
source/evo_xb_pmux.sv
source/evo_xb.sv
testbench/evo_xb_tb.sv

/* source/evo_csr_pkg.sv */
// CSR bus widths, register address map and info block constants shared by all bus responders
`default_nettype none

package evo_csr_pkg;

   // -------------------------------------------------------------------------
   // Bus widths
   // -------------------------------------------------------------------------
   localparam int CSR_AWIDTH = 8;
   localparam int CSR_DWIDTH = 32;

   typedef logic [CSR_AWIDTH-1:0] csr_addr_t;
   typedef logic [CSR_DWIDTH-1:0] csr_data_t;

   // -------------------------------------------------------------------------
   // Info block
   // -------------------------------------------------------------------------
   localparam csr_addr_t INFO_BASE        = 8'h00;
   localparam csr_addr_t INFO_ID_OFS      = 8'd0;
   localparam csr_addr_t INFO_VER_OFS     = 8'd1;
   localparam csr_addr_t INFO_SCRATCH_OFS = 8'd2;

   // ASCII "EVOX"
   localparam csr_data_t INFO_ID_VALUE  = 32'h45564F58;
   // Major 1, minor 2
   localparam csr_data_t INFO_VER_VALUE = 32'h00010002;

   // -------------------------------------------------------------------------
   // Port controllers
   // -------------------------------------------------------------------------
   localparam csr_addr_t PMUX_D_BASE = 8'h10;
   localparam csr_addr_t PMUX_E_BASE = 8'h20;

   // Register offsets inside one port controller
   localparam csr_addr_t PMUX_SLOT_OFS = 8'd0;
   localparam csr_addr_t PMUX_DIR_OFS  = 8'd1;
   localparam csr_addr_t PMUX_OUT_OFS  = 8'd2;
   localparam csr_addr_t PMUX_EN_OFS   = 8'd3;
   localparam csr_addr_t PMUX_IN_OFS   = 8'd4;

endpackage

`default_nettype wire

/* source/evo_pmux_csr.sv */
// Port controller registers: slot select, per-slot DIR/OUT/EN words and pin sampling over CSR
`timescale 1ns/100ps
`default_nettype none

module evo_pmux_csr #(
   parameter type                     pin_t     = evo_pmux_pkg::port_d_t,
   parameter evo_csr_pkg::csr_addr_t  BASE_ADDR = evo_csr_pkg::PMUX_D_BASE
) (
   input  logic                                  clk,
   input  logic                                  rst_i,
   input  evo_csr_pkg::csr_addr_t                address_i,
   input  logic                                  read_i,
   input  logic                                  write_i,
   input  evo_csr_pkg::csr_data_t                writedata_i,
   input  pin_t                                  pin_i,
   output evo_csr_pkg::csr_data_t                rsp_data_o,
   output logic                                  rsp_valid_o,
   output pin_t [evo_pmux_pkg::PMUX_SLOTS-1:0]   slot_dir_o,
   output pin_t [evo_pmux_pkg::PMUX_SLOTS-1:0]   slot_out_o,
   output pin_t [evo_pmux_pkg::PMUX_SLOTS-1:0]   slot_en_o
);

   localparam int PIN_W = $bits(pin_t);
   localparam int SEL_W = $bits(evo_pmux_pkg::slot_idx_t);

   // -------------------------------------------------------------------------
   // Register addresses for this port
   // -------------------------------------------------------------------------
   localparam evo_csr_pkg::csr_addr_t ADDR_SLOT = BASE_ADDR + evo_csr_pkg::PMUX_SLOT_OFS;
   localparam evo_csr_pkg::csr_addr_t ADDR_DIR  = BASE_ADDR + evo_csr_pkg::PMUX_DIR_OFS;
   localparam evo_csr_pkg::csr_addr_t ADDR_OUT  = BASE_ADDR + evo_csr_pkg::PMUX_OUT_OFS;
   localparam evo_csr_pkg::csr_addr_t ADDR_EN   = BASE_ADDR + evo_csr_pkg::PMUX_EN_OFS;
   localparam evo_csr_pkg::csr_addr_t ADDR_IN   = BASE_ADDR + evo_csr_pkg::PMUX_IN_OFS;

   evo_pmux_pkg::slot_idx_t slot_sel_q;
   pin_t                    in_q;
   pin_t                    wr_pins;
   evo_csr_pkg::csr_data_t  rd_data;
   logic                    rd_hit;

   // Upper write data bits beyond the port width are dropped
   assign wr_pins = writedata_i[PIN_W-1:0];

   // -------------------------------------------------------------------------
   // Slot registers
   // -------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst_i) begin
         slot_sel_q <= '0;
         slot_dir_o <= '0;
         slot_out_o <= '0;
         slot_en_o  <= '0;
      end else if (write_i) begin
         case (address_i)
            ADDR_SLOT: slot_sel_q             <= writedata_i[SEL_W-1:0];
            ADDR_DIR:  slot_dir_o[slot_sel_q] <= wr_pins;
            ADDR_OUT:  slot_out_o[slot_sel_q] <= wr_pins;
            ADDR_EN:   slot_en_o[slot_sel_q]  <= wr_pins;
            default:   ;
         endcase
      end
   end

   // Pin sample, free running
   always_ff @(posedge clk) begin
      in_q <= pin_i;
   end

   // -------------------------------------------------------------------------
   // Read path
   // -------------------------------------------------------------------------
   always_comb begin
      rd_hit  = 1'b1;
      rd_data = '0;
      case (address_i)
         ADDR_SLOT: rd_data = evo_csr_pkg::csr_data_t'(slot_sel_q);
         ADDR_DIR:  rd_data = evo_csr_pkg::csr_data_t'(slot_dir_o[slot_sel_q]);
         ADDR_OUT:  rd_data = evo_csr_pkg::csr_data_t'(slot_out_o[slot_sel_q]);
         ADDR_EN:   rd_data = evo_csr_pkg::csr_data_t'(slot_en_o[slot_sel_q]);
         ADDR_IN:   rd_data = evo_csr_pkg::csr_data_t'(in_q);
         default:   rd_hit  = 1'b0;
      endcase
   end

   // Response one cycle after the read, zeros otherwise
   always_ff @(posedge clk) begin
      if (rst_i) begin
         rsp_valid_o <= 1'b0;
         rsp_data_o  <= '0;
      end else begin
         rsp_valid_o <= read_i & rd_hit;
         rsp_data_o  <= (read_i && rd_hit) ? rd_data : '0;
      end
   end

endmodule

`default_nettype wire

/* source/evo_pmux_pkg.sv */
// Port widths, slot count and pin vector types used by the pin multiplexer logic
`default_nettype none

package evo_pmux_pkg;

   // -------------------------------------------------------------------------
   // Port sizes
   // -------------------------------------------------------------------------
   localparam int PORT_D_DWIDTH = 8;
   localparam int PORT_E_DWIDTH = 6;

   // Drive slots per port, lowest slot has priority
   localparam int PMUX_SLOTS = 4;

   // -------------------------------------------------------------------------
   // Types
   // -------------------------------------------------------------------------
   typedef logic [$clog2(PMUX_SLOTS)-1:0] slot_idx_t;

   typedef logic [PORT_D_DWIDTH-1:0] port_d_t;
   typedef logic [PORT_E_DWIDTH-1:0] port_e_t;

endpackage

`default_nettype wire

/* source/evo_xb.sv */
// Pin multiplexer top level: info block and two port controllers sharing one CSR bus
`timescale 1ns/100ps
`default_nettype none

module evo_xb (
   input  logic                   clk,
   input  logic                   rst_i,
   // CSR bus
   input  evo_csr_pkg::csr_addr_t address_i,
   input  logic                   read_i,
   input  logic                   write_i,
   input  evo_csr_pkg::csr_data_t writedata_i,
   output evo_csr_pkg::csr_data_t readdata_o,
   output logic                   readdatavalid_o,
   // Port D pins
   input  evo_pmux_pkg::port_d_t  port_d_in_i,
   output evo_pmux_pkg::port_d_t  port_d_dir_o,
   output evo_pmux_pkg::port_d_t  port_d_out_o,
   output evo_pmux_pkg::port_d_t  port_d_en_o,
   // Port E pins
   input  evo_pmux_pkg::port_e_t  port_e_in_i,
   output evo_pmux_pkg::port_e_t  port_e_dir_o,
   output evo_pmux_pkg::port_e_t  port_e_out_o,
   output evo_pmux_pkg::port_e_t  port_e_en_o
);

   // Responder outputs
   evo_csr_pkg::csr_data_t info_rsp_data;
   logic                   info_rsp_valid;
   evo_csr_pkg::csr_data_t d_rsp_data;
   logic                   d_rsp_valid;
   evo_csr_pkg::csr_data_t e_rsp_data;
   logic                   e_rsp_valid;

   // Slot words from each controller into its merge
   evo_pmux_pkg::port_d_t [evo_pmux_pkg::PMUX_SLOTS-1:0] d_slot_dir;
   evo_pmux_pkg::port_d_t [evo_pmux_pkg::PMUX_SLOTS-1:0] d_slot_out;
   evo_pmux_pkg::port_d_t [evo_pmux_pkg::PMUX_SLOTS-1:0] d_slot_en;
   evo_pmux_pkg::port_e_t [evo_pmux_pkg::PMUX_SLOTS-1:0] e_slot_dir;
   evo_pmux_pkg::port_e_t [evo_pmux_pkg::PMUX_SLOTS-1:0] e_slot_out;
   evo_pmux_pkg::port_e_t [evo_pmux_pkg::PMUX_SLOTS-1:0] e_slot_en;

   // Idle responders drive zeros, so a plain OR combines them
   assign readdata_o      = info_rsp_data | d_rsp_data | e_rsp_data;
   assign readdatavalid_o = info_rsp_valid | d_rsp_valid | e_rsp_valid;

   // -------------------------------------------------------------------------
   // Info block
   // -------------------------------------------------------------------------
   evo_xb_info evo_xb_info_inst (
      .clk         (clk),
      .rst_i       (rst_i),
      .address_i   (address_i),
      .read_i      (read_i),
      .write_i     (write_i),
      .writedata_i (writedata_i),
      .rsp_data_o  (info_rsp_data),
      .rsp_valid_o (info_rsp_valid)
   );

   // -------------------------------------------------------------------------
   // Port D
   // -------------------------------------------------------------------------
   evo_pmux_csr #(
      .pin_t     (evo_pmux_pkg::port_d_t),
      .BASE_ADDR (evo_csr_pkg::PMUX_D_BASE)
   ) evo_d_pmux_csr_inst (
      .clk         (clk),
      .rst_i       (rst_i),
      .address_i   (address_i),
      .read_i      (read_i),
      .write_i     (write_i),
      .writedata_i (writedata_i),
      .pin_i       (port_d_in_i),
      .rsp_data_o  (d_rsp_data),
      .rsp_valid_o (d_rsp_valid),
      .slot_dir_o  (d_slot_dir),
      .slot_out_o  (d_slot_out),
      .slot_en_o   (d_slot_en)
   );

   evo_xb_pmux #(
      .pin_t (evo_pmux_pkg::port_d_t)
   ) evo_d_pmux_inst (
      .slot_dir_i (d_slot_dir),
      .slot_out_i (d_slot_out),
      .slot_en_i  (d_slot_en),
      .dir_o      (port_d_dir_o),
      .out_o      (port_d_out_o),
      .en_o       (port_d_en_o)
   );

   // -------------------------------------------------------------------------
   // Port E
   // -------------------------------------------------------------------------
   evo_pmux_csr #(
      .pin_t     (evo_pmux_pkg::port_e_t),
      .BASE_ADDR (evo_csr_pkg::PMUX_E_BASE)
   ) evo_e_pmux_csr_inst (
      .clk         (clk),
      .rst_i       (rst_i),
      .address_i   (address_i),
      .read_i      (read_i),
      .write_i     (write_i),
      .writedata_i (writedata_i),
      .pin_i       (port_e_in_i),
      .rsp_data_o  (e_rsp_data),
      .rsp_valid_o (e_rsp_valid),
      .slot_dir_o  (e_slot_dir),
      .slot_out_o  (e_slot_out),
      .slot_en_o   (e_slot_en)
   );

   evo_xb_pmux #(
      .pin_t (evo_pmux_pkg::port_e_t)
   ) evo_e_pmux_inst (
      .slot_dir_i (e_slot_dir),
      .slot_out_i (e_slot_out),
      .slot_en_i  (e_slot_en),
      .dir_o      (port_e_dir_o),
      .out_o      (port_e_out_o),
      .en_o       (port_e_en_o)
   );

endmodule

`default_nettype wire

/* source/evo_xb_info.sv */
// Info block on the CSR bus: fixed ID and version words plus a scratch register for the host
`timescale 1ns/100ps
`default_nettype none

module evo_xb_info (
   input  logic                   clk,
   input  logic                   rst_i,
   input  evo_csr_pkg::csr_addr_t address_i,
   input  logic                   read_i,
   input  logic                   write_i,
   input  evo_csr_pkg::csr_data_t writedata_i,
   output evo_csr_pkg::csr_data_t rsp_data_o,
   output logic                   rsp_valid_o
);

   localparam evo_csr_pkg::csr_addr_t ADDR_ID =
      evo_csr_pkg::INFO_BASE + evo_csr_pkg::INFO_ID_OFS;
   localparam evo_csr_pkg::csr_addr_t ADDR_VER =
      evo_csr_pkg::INFO_BASE + evo_csr_pkg::INFO_VER_OFS;
   localparam evo_csr_pkg::csr_addr_t ADDR_SCRATCH =
      evo_csr_pkg::INFO_BASE + evo_csr_pkg::INFO_SCRATCH_OFS;

   evo_csr_pkg::csr_data_t scratch_q;
   evo_csr_pkg::csr_data_t rd_data;
   logic                   rd_hit;

   // Read decode
   always_comb begin
      rd_hit  = 1'b1;
      rd_data = '0;
      case (address_i)
         ADDR_ID:      rd_data = evo_csr_pkg::INFO_ID_VALUE;
         ADDR_VER:     rd_data = evo_csr_pkg::INFO_VER_VALUE;
         ADDR_SCRATCH: rd_data = scratch_q;
         default:      rd_hit  = 1'b0;
      endcase
   end

   // Scratch write and one-cycle read response
   always_ff @(posedge clk) begin
      if (rst_i) begin
         scratch_q   <= '0;
         rsp_valid_o <= 1'b0;
         rsp_data_o  <= '0;
      end else begin
         if (write_i && (address_i == ADDR_SCRATCH)) begin
            scratch_q <= writedata_i;
         end
         rsp_valid_o <= read_i & rd_hit;
         // Zero when idle so the top level can OR responses
         rsp_data_o  <= (read_i && rd_hit) ? rd_data : '0;
      end
   end

endmodule

`default_nettype wire

/* source/evo_xb_pmux.sv */
// Combinational per-pin priority merge of the drive slots into one pin drive word
`timescale 1ns/100ps
`default_nettype none

module evo_xb_pmux #(
   parameter type pin_t = evo_pmux_pkg::port_d_t
) (
   input  pin_t [evo_pmux_pkg::PMUX_SLOTS-1:0] slot_dir_i,
   input  pin_t [evo_pmux_pkg::PMUX_SLOTS-1:0] slot_out_i,
   input  pin_t [evo_pmux_pkg::PMUX_SLOTS-1:0] slot_en_i,
   output pin_t                                dir_o,
   output pin_t                                out_o,
   output pin_t                                en_o
);

   localparam int PIN_W = $bits(pin_t);

   // -------------------------------------------------------------------------
   // Merge
   // -------------------------------------------------------------------------
   // Slots are scanned from the highest down, so the lowest enabled slot
   // is the last to write a pin and wins
   always_comb begin
      dir_o = '0;
      out_o = '0;
      en_o  = '0;
      for (int p = 0; p < PIN_W; p++) begin
         for (int s = evo_pmux_pkg::PMUX_SLOTS - 1; s >= 0; s--) begin
            if (slot_en_i[s][p]) begin
               dir_o[p] = slot_dir_i[s][p];
               out_o[p] = slot_out_i[s][p];
            end
            en_o[p] = en_o[p] | slot_en_i[s][p];
         end
      end
   end

endmodule

`default_nettype wire

/* testbench/evo_xb_tb.sv */
// Table-driven testbench that runs as the simulation top and drives the pin multiplexer top level
`timescale 1ns/100ps
`default_nettype none

module evo_xb_tb;

   // Row operations
   localparam int OP_WR      = 0;
   localparam int OP_RD      = 1;
   localparam int OP_RD_NONE = 2;
   localparam int OP_PINS    = 3;
   localparam int OP_CHK_D   = 4;
   localparam int OP_CHK_E   = 5;

   localparam evo_csr_pkg::csr_addr_t A_ID  = evo_csr_pkg::INFO_BASE + evo_csr_pkg::INFO_ID_OFS;
   localparam evo_csr_pkg::csr_addr_t A_VER = evo_csr_pkg::INFO_BASE + evo_csr_pkg::INFO_VER_OFS;
   localparam evo_csr_pkg::csr_addr_t A_SCR =
      evo_csr_pkg::INFO_BASE + evo_csr_pkg::INFO_SCRATCH_OFS;
   localparam evo_csr_pkg::csr_addr_t D_SLOT =
      evo_csr_pkg::PMUX_D_BASE + evo_csr_pkg::PMUX_SLOT_OFS;
   localparam evo_csr_pkg::csr_addr_t D_DIR  = evo_csr_pkg::PMUX_D_BASE + evo_csr_pkg::PMUX_DIR_OFS;
   localparam evo_csr_pkg::csr_addr_t D_OUT  = evo_csr_pkg::PMUX_D_BASE + evo_csr_pkg::PMUX_OUT_OFS;
   localparam evo_csr_pkg::csr_addr_t D_EN   = evo_csr_pkg::PMUX_D_BASE + evo_csr_pkg::PMUX_EN_OFS;
   localparam evo_csr_pkg::csr_addr_t D_IN   = evo_csr_pkg::PMUX_D_BASE + evo_csr_pkg::PMUX_IN_OFS;
   localparam evo_csr_pkg::csr_addr_t E_SLOT =
      evo_csr_pkg::PMUX_E_BASE + evo_csr_pkg::PMUX_SLOT_OFS;
   localparam evo_csr_pkg::csr_addr_t E_OUT  = evo_csr_pkg::PMUX_E_BASE + evo_csr_pkg::PMUX_OUT_OFS;
   localparam evo_csr_pkg::csr_addr_t E_EN   = evo_csr_pkg::PMUX_E_BASE + evo_csr_pkg::PMUX_EN_OFS;
   localparam evo_csr_pkg::csr_addr_t E_IN   = evo_csr_pkg::PMUX_E_BASE + evo_csr_pkg::PMUX_IN_OFS;

   logic                   clk;
   logic                   rst_i       = 1'b1;
   evo_csr_pkg::csr_addr_t address_i   = '0;
   logic                   read_i      = 1'b0;
   logic                   write_i     = 1'b0;
   evo_csr_pkg::csr_data_t writedata_i = '0;
   evo_csr_pkg::csr_data_t readdata_o;
   logic                   readdatavalid_o;
   evo_pmux_pkg::port_d_t  port_d_in_i = '0;
   evo_pmux_pkg::port_d_t  port_d_dir_o;
   evo_pmux_pkg::port_d_t  port_d_out_o;
   evo_pmux_pkg::port_d_t  port_d_en_o;
   evo_pmux_pkg::port_e_t  port_e_in_i = '0;
   evo_pmux_pkg::port_e_t  port_e_dir_o;
   evo_pmux_pkg::port_e_t  port_e_out_o;
   evo_pmux_pkg::port_e_t  port_e_en_o;

   integer seed         = 32'hd8f5b764;
   int     mismatch_cnt = 0;
   int     fail_cnt     = 0;
   int     cycle_cnt    = 0;
   int     cycle_limit  = 100;

   // Stimulus table held as parallel queues with one entry per row
   int                     op_q[$];
   evo_csr_pkg::csr_addr_t addr_q[$];
   evo_csr_pkg::csr_data_t data_q[$];
   evo_csr_pkg::csr_data_t exp_q[$];

   evo_xb u_dut (
      .clk             (clk),
      .rst_i           (rst_i),
      .address_i       (address_i),
      .read_i          (read_i),
      .write_i         (write_i),
      .writedata_i     (writedata_i),
      .readdata_o      (readdata_o),
      .readdatavalid_o (readdatavalid_o),
      .port_d_in_i     (port_d_in_i),
      .port_d_dir_o    (port_d_dir_o),
      .port_d_out_o    (port_d_out_o),
      .port_d_en_o     (port_d_en_o),
      .port_e_in_i     (port_e_in_i),
      .port_e_dir_o    (port_e_dir_o),
      .port_e_out_o    (port_e_out_o),
      .port_e_en_o     (port_e_en_o)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // ------------------------------------------------------------------------
   // Compare tasks
   // ------------------------------------------------------------------------
   task automatic check_data(input string name, input evo_csr_pkg::csr_data_t exp_val,
                             input evo_csr_pkg::csr_data_t act_val);
      if (act_val !== exp_val) begin
         $display("MISMATCH at %0t: %s expected 0x%08h, got 0x%08h",
                  $time, name, exp_val, act_val);
         mismatch_cnt++;
      end
   endtask

   task automatic check_port_d(input string name, input evo_pmux_pkg::port_d_t exp_val,
                               input evo_pmux_pkg::port_d_t act_val);
      if (act_val !== exp_val) begin
         $display("MISMATCH at %0t: %s expected 0x%02h, got 0x%02h",
                  $time, name, exp_val, act_val);
         mismatch_cnt++;
      end
   endtask

   task automatic check_port_e(input string name, input evo_pmux_pkg::port_e_t exp_val,
                               input evo_pmux_pkg::port_e_t act_val);
      if (act_val !== exp_val) begin
         $display("MISMATCH at %0t: %s expected 0x%02h, got 0x%02h",
                  $time, name, exp_val, act_val);
         mismatch_cnt++;
      end
   endtask

   task automatic add_row(input int op, input evo_csr_pkg::csr_addr_t addr,
                          input evo_csr_pkg::csr_data_t data,
                          input evo_csr_pkg::csr_data_t exp_val);
      op_q.push_back(op);
      addr_q.push_back(addr);
      data_q.push_back(data);
      exp_q.push_back(exp_val);
   endtask

   // ------------------------------------------------------------------------
   // Table contents
   // ------------------------------------------------------------------------
   task automatic load_table();
      // Info block
      add_row(OP_RD, A_ID, 0, evo_csr_pkg::INFO_ID_VALUE);
      add_row(OP_RD, A_VER, 0, evo_csr_pkg::INFO_VER_VALUE);
      add_row(OP_WR, A_SCR, 32'h1234ABCD, 0);
      add_row(OP_RD, A_SCR, 0, 32'h1234ABCD);
      // Reset state of all pin outputs
      // Check address 0 is dir, 1 is out and 2 is en
      for (int i = 0; i < 3; i++) begin
         add_row(OP_CHK_D, i, 0, 0);
         add_row(OP_CHK_E, i, 0, 0);
      end
      add_row(OP_RD_NONE, 8'h40, 0, 0);
      // Port D slot 0 drives the low nibble
      add_row(OP_WR, D_SLOT, 0, 0);
      add_row(OP_WR, D_DIR, 32'hFF, 0);
      add_row(OP_WR, D_OUT, 32'h0F, 0);
      add_row(OP_WR, D_EN, 32'h0F, 0);
      add_row(OP_CHK_D, 0, 0, 32'h0F);
      add_row(OP_CHK_D, 1, 0, 32'h0F);
      add_row(OP_CHK_D, 2, 0, 32'h0F);
      // Slot 2 loses pins 0 to 3 against slot 0
      add_row(OP_WR, D_SLOT, 2, 0);
      add_row(OP_WR, D_DIR, 32'hFF, 0);
      add_row(OP_WR, D_OUT, 32'hF0, 0);
      add_row(OP_WR, D_EN, 32'hFF, 0);
      add_row(OP_CHK_D, 0, 0, 32'hFF);
      add_row(OP_CHK_D, 1, 0, 32'hFF);
      add_row(OP_CHK_D, 2, 0, 32'hFF);
      add_row(OP_RD, D_DIR, 0, 32'hFF);
      // Slot 0 holds 0x0F here, so this read tells the slots apart
      add_row(OP_RD, D_OUT, 0, 32'hF0);
      add_row(OP_RD, D_SLOT, 0, 2);
      // Port E slot select keeps only two bits
      add_row(OP_WR, E_SLOT, 5, 0);
      add_row(OP_RD, E_SLOT, 0, 1);
      add_row(OP_WR, E_OUT, 32'hFFFFFFFF, 0);
      add_row(OP_WR, E_EN, 32'hFFFFFFFF, 0);
      add_row(OP_RD, E_OUT, 0, 32'h3F);
      add_row(OP_CHK_E, 0, 0, 0);
      add_row(OP_CHK_E, 1, 0, 32'h3F);
      add_row(OP_CHK_E, 2, 0, 32'h3F);
      // Pin readback with address 0 for port D and 1 for port E
      add_row(OP_PINS, 0, 32'hA5, 0);
      add_row(OP_PINS, 1, 32'h2C, 0);
      add_row(OP_RD, D_IN, 0, 32'hA5);
      add_row(OP_RD, E_IN, 0, 32'h2C);
   endtask

   // Response is due exactly one cycle after the accepting edge
   task automatic read_reg(input evo_csr_pkg::csr_addr_t addr,
                           input evo_csr_pkg::csr_data_t exp_val, input bit expect_rsp);
      @(posedge clk);
      address_i <= addr;
      read_i    <= 1'b1;
      @(negedge clk);
      if (readdatavalid_o !== 1'b0) begin
         $display("Read of 0x%02h got a response before it was accepted", addr);
         fail_cnt++;
      end
      @(posedge clk);
      read_i <= 1'b0;
      @(negedge clk);
      if (expect_rsp && readdatavalid_o !== 1'b1) begin
         $display("Read of 0x%02h got no response one cycle after acceptance", addr);
         fail_cnt++;
      end else if (expect_rsp) begin
         check_data("readdata_o", exp_val, readdata_o);
      end else if (readdatavalid_o !== 1'b0) begin
         $display("Read of unmapped address 0x%02h got a response", addr);
         fail_cnt++;
      end
   endtask

   task automatic run_row(input int idx);
      int                     op;
      evo_csr_pkg::csr_addr_t addr;
      evo_csr_pkg::csr_data_t data;
      evo_csr_pkg::csr_data_t exp_val;
      op      = op_q[idx];
      addr    = addr_q[idx];
      data    = data_q[idx];
      exp_val = exp_q[idx];
      case (op)
         OP_WR: begin
            @(posedge clk);
            address_i   <= addr;
            writedata_i <= data;
            write_i     <= 1'b1;
            @(posedge clk);
            write_i     <= 1'b0;
         end
         OP_RD:      read_reg(addr, exp_val, 1'b1);
         OP_RD_NONE: read_reg(addr, exp_val, 1'b0);
         OP_PINS: begin
            @(posedge clk);
            if (addr == 0) port_d_in_i <= evo_pmux_pkg::port_d_t'(data);
            else port_e_in_i <= evo_pmux_pkg::port_e_t'(data);
            repeat (2) @(posedge clk);
         end
         OP_CHK_D: begin
            @(negedge clk);
            case (addr)
               0:       check_port_d("port_d_dir_o", exp_val[7:0], port_d_dir_o);
               1:       check_port_d("port_d_out_o", exp_val[7:0], port_d_out_o);
               default: check_port_d("port_d_en_o", exp_val[7:0], port_d_en_o);
            endcase
         end
         default: begin
            @(negedge clk);
            case (addr)
               0:       check_port_e("port_e_dir_o", exp_val[5:0], port_e_dir_o);
               1:       check_port_e("port_e_out_o", exp_val[5:0], port_e_out_o);
               default: check_port_e("port_e_en_o", exp_val[5:0], port_e_en_o);
            endcase
         end
      endcase
   endtask

   task automatic print_counts();
      $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
   endtask

   // ------------------------------------------------------------------------
   // Watchdog and main sequence
   // ------------------------------------------------------------------------
   always @(posedge clk) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt > cycle_limit) begin
         $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
         fail_cnt++;
         print_counts();
         $display("Some tests failed");
         $finish;
      end
   end

   initial begin
      load_table();
      cycle_limit = 4 * op_q.size() + 100;
      repeat (8) @(posedge clk);
      rst_i <= 1'b0;
      @(negedge clk);
      if (readdatavalid_o !== 1'b0) begin
         $display("readdatavalid_o is not low after reset");
         fail_cnt++;
      end
      for (int i = 0; i < op_q.size(); i++) begin
         run_row(i);
      end
      @(posedge clk);
      print_counts();
      if (mismatch_cnt == 0 && fail_cnt == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
